//--- design/fpAdder_config.svh
`ifndef FP_ADDER_CONFIG_SVH
`define FP_ADDER_CONFIG_SVH

// IEEE-754 single-precision field widths
`define FP_EXP_W 8         // Biased exponent
`define FP_MAN_W 23        // Stored fraction
`define FP_SIG_W 24        // Fraction plus implicit one

// Latency from inValid to outValid, one cycle per stage
`define FP_PIPE_DEPTH 3

`endif

//--- design/fpAdderPkg.sv
`default_nettype none
`include "fpAdder_config.svh"

package fpAdderPkg;

    typedef logic [`FP_EXP_W-1:0] exponent_t;                   // Biased exponent
    typedef logic [`FP_MAN_W-1:0] mantissa_t;                   // Stored fraction
    typedef logic [`FP_SIG_W-1:0] significand_t;                // Fraction with implicit one
    typedef logic [`FP_SIG_W:0] sumSig_t;                       // Significand plus carry-out
    typedef logic [`FP_EXP_W+`FP_MAN_W:0] floatWord_t;          // Packed IEEE word

    // Same bit layout as an IEEE word, so a floatWord_t casts straight across
    typedef struct packed
    {
        logic sign;                                             // Sign bit
        exponent_t exponent;                                    // Biased exponent
        mantissa_t mantissa;                                    // Fraction, implicit one dropped
    } operand_t;

    // Alignment stage to significand stage
    typedef struct packed
    {
        logic signA;                                            // Sign of operand A
        logic signB;                                            // Sign of operand B
        exponent_t exponentOut;                                 // Larger of the two exponents
        significand_t alignedMantissaA;                         // A after alignment
        significand_t alignedMantissaB;                         // B after alignment
        logic guardBit;                                         // First bit shifted out
        logic roundBit;                                         // Second bit shifted out
        logic stickyBit;                                        // OR of everything further down
    } alignedPair_t;

    // Significand stage to normalize/round stage
    typedef struct packed
    {
        logic sign;                                             // Sign of the result
        exponent_t exponent;                                    // Exponent before normalization
        sumSig_t sum;                                           // Sum with carry-out on top
        logic guardBit;                                         // Guard after the add
        logic roundBit;                                         // Round after the add
        logic stickyBit;                                        // Sticky after the add
        logic isZero;                                           // Exact cancellation
    } sumResult_t;

endpackage

`default_nettype wire

//--- design/Alignment.sv
`timescale 1ns/1ps
`default_nettype none
`include "fpAdder_config.svh"

module Alignment
(
    input  logic clk,
    input  logic reset,
    input  logic inValid,
    input  fpAdderPkg::operand_t operandA,
    input  fpAdderPkg::operand_t operandB,
    output logic alignValid,
    output fpAdderPkg::alignedPair_t aligned
);

    localparam int WideW = 2 * `FP_SIG_W + 2;                   // Significand plus room for all shifted bits
    localparam int MaxShift = `FP_SIG_W + 2;                    // Beyond this only sticky survives

    logic shiftB;                                               // B has the smaller (or equal) exponent
    fpAdderPkg::exponent_t expDiff;                             // Right-shift amount
    fpAdderPkg::significand_t sigA;                             // A with implicit one
    fpAdderPkg::significand_t sigB;                             // B with implicit one
    fpAdderPkg::significand_t sigSmall;                         // Operand that gets shifted
    fpAdderPkg::significand_t sigShifted;                       // Its aligned value
    logic [WideW-1:0] shiftWide;                                // Shifted value with every lost bit kept
    logic guardNext;
    logic roundNext;
    logic stickyNext;
    fpAdderPkg::alignedPair_t alignedNext;

    always_comb
    begin
        sigA = {1'b1, operandA.mantissa};                       // Restore implicit ones
        sigB = {1'b1, operandB.mantissa};
        shiftB = (operandA.exponent >= operandB.exponent);      // Ties shift B by zero

        if (shiftB)
        begin
            expDiff = operandA.exponent - operandB.exponent;
            sigSmall = sigB;
        end
        else
        begin
            expDiff = operandB.exponent - operandA.exponent;
            sigSmall = sigA;
        end

        // Low 26 bits catch guard, round and everything that feeds sticky
        shiftWide = {sigSmall, {MaxShift{1'b0}}} >> expDiff;

        if (expDiff > MaxShift)
        begin
            sigShifted = '0;                                    // Whole operand is below round
            guardNext = 1'b0;
            roundNext = 1'b0;
            stickyNext = |sigSmall;
        end
        else
        begin
            sigShifted = shiftWide[WideW-1 -: `FP_SIG_W];
            guardNext = shiftWide[`FP_SIG_W+1];
            roundNext = shiftWide[`FP_SIG_W];
            stickyNext = |shiftWide[`FP_SIG_W-1:0];             // Everything below round
        end

        alignedNext.signA = operandA.sign;
        alignedNext.signB = operandB.sign;
        alignedNext.exponentOut = shiftB ? operandA.exponent : operandB.exponent;
        alignedNext.alignedMantissaA = shiftB ? sigA : sigShifted;
        alignedNext.alignedMantissaB = shiftB ? sigShifted : sigB;
        alignedNext.guardBit = guardNext;
        alignedNext.roundBit = roundNext;
        alignedNext.stickyBit = stickyNext;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            alignValid <= 1'b0;
            aligned <= '0;
        end
        else
        begin
            alignValid <= inValid;                              // One-cycle stage
            aligned <= alignedNext;
        end
    end

endmodule

`default_nettype wire

//--- design/SignificandAdder.sv
`timescale 1ns/1ps
`default_nettype none
`include "fpAdder_config.svh"

module SignificandAdder
(
    input  logic clk,
    input  logic reset,
    input  logic alignValid,
    input  fpAdderPkg::alignedPair_t aligned,
    output logic sumValid,
    output fpAdderPkg::sumResult_t sum
);

    localparam int OpW = `FP_SIG_W + 3;                         // Significand plus guard, round, sticky

    logic [2:0] grsBits;                                        // Low bits of the shifted operand
    logic grsToA;                                               // A was the shifted operand
    logic [OpW-1:0] opA;
    logic [OpW-1:0] opB;
    logic [OpW-1:0] opLarge;
    logic [OpW-1:0] opSmall;
    logic [OpW:0] rawSum;                                       // One extra bit for the carry
    logic effSub;                                               // Signs differ
    logic aLarger;                                              // |A| >= |B|
    logic nextZero;
    logic nextSign;
    fpAdderPkg::sumResult_t sumNext;

    always_comb
    begin
        grsBits = {aligned.guardBit, aligned.roundBit, aligned.stickyBit};

        // Unshifted operand keeps its leading one, so a cleared MSB marks the shifted one
        grsToA = ~aligned.alignedMantissaA[`FP_SIG_W-1];
        opA = {aligned.alignedMantissaA, grsToA ? grsBits : 3'b000};
        opB = {aligned.alignedMantissaB, grsToA ? 3'b000 : grsBits};

        effSub = aligned.signA ^ aligned.signB;
        aLarger = (opA >= opB);
        opLarge = aLarger ? opA : opB;
        opSmall = aLarger ? opB : opA;

        if (effSub)
            rawSum = {1'b0, opLarge} - {1'b0, opSmall};         // Never negative
        else
            rawSum = {1'b0, opA} + {1'b0, opB};

        nextZero = effSub && (rawSum == '0);                    // x - x

        if (nextZero)
            nextSign = 1'b0;                                    // Exact cancellation is +0
        else if (effSub)
            nextSign = aLarger ? aligned.signA : aligned.signB; // Larger magnitude wins
        else
            nextSign = aligned.signA;

        sumNext.sign = nextSign;
        sumNext.exponent = aligned.exponentOut;
        sumNext.sum = rawSum[OpW:3];
        sumNext.guardBit = rawSum[2];
        sumNext.roundBit = rawSum[1];
        sumNext.stickyBit = rawSum[0];
        sumNext.isZero = nextZero;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sumValid <= 1'b0;
            sum <= '0;
        end
        else
        begin
            sumValid <= alignValid;
            sum <= sumNext;
        end
    end

endmodule

`default_nettype wire

//--- design/NormalizeRound.sv
`timescale 1ns/1ps
`default_nettype none
`include "fpAdder_config.svh"

module NormalizeRound
(
    input  logic clk,
    input  logic reset,
    input  logic sumValid,
    input  fpAdderPkg::sumResult_t sum,
    output logic outValid,
    output fpAdderPkg::floatWord_t result
);

    localparam int NormW = `FP_SIG_W + 2;                       // Significand plus guard and round
    localparam int LzW = $clog2(NormW + 1);                     // Count can reach NormW
    localparam int ExpMax = (1 << `FP_EXP_W) - 1;               // 255, reserved for infinity
    localparam int ExpW = `FP_EXP_W + 2;                        // Headroom for over/underflow

    logic [NormW-1:0] normIn;                                   // Bits that can move up on a left shift
    logic [NormW-1:0] normShifted;
    logic [LzW-1:0] lzCount;
    logic signed [ExpW-1:0] expIn;
    logic signed [ExpW-1:0] expNorm;                            // After normalization
    logic signed [ExpW-1:0] expFinal;                           // After rounding carry
    fpAdderPkg::significand_t sigNorm;
    logic guardN;
    logic roundN;
    logic stickyN;
    logic roundUp;
    logic [`FP_SIG_W:0] sigRounded;                             // Room for the rounding carry
    fpAdderPkg::mantissa_t fracOut;
    fpAdderPkg::floatWord_t resultNext;

    // Position of the highest set bit, counted from the top
    function automatic logic [LzW-1:0] countLeadingZeros(input logic [NormW-1:0] value);
        logic [LzW-1:0] count;
        count = LzW'(NormW);                                    // All zero
        for (int i = 0; i < NormW; i++)
        begin
            if (value[i])
                count = LzW'(NormW - 1 - i);                    // Highest hit wins
        end
        return count;
    endfunction

    always_comb
    begin
        normIn = {sum.sum[`FP_SIG_W-1:0], sum.guardBit, sum.roundBit};
        lzCount = countLeadingZeros(normIn);
        normShifted = normIn << lzCount;
        expIn = {2'b00, sum.exponent};

        if (sum.sum[`FP_SIG_W])
        begin
            // Carry out of the add, shift right one
            sigNorm = sum.sum[`FP_SIG_W:1];
            guardN = sum.sum[0];
            roundN = sum.guardBit;
            stickyN = sum.roundBit | sum.stickyBit;             // Old round folds into sticky
            expNorm = expIn + ExpW'(1);
        end
        else
        begin
            sigNorm = normShifted[NormW-1:2];                   // Filled from guard and round
            guardN = normShifted[1];
            roundN = normShifted[0];
            stickyN = sum.stickyBit;
            expNorm = expIn - {{(ExpW-LzW){1'b0}}, lzCount};
        end

        // Nearest even: round up above half, or at half when the LSB is odd
        roundUp = guardN & (roundN | stickyN | sigNorm[0]);
        sigRounded = {1'b0, sigNorm} + {{`FP_SIG_W{1'b0}}, roundUp};

        if (sigRounded[`FP_SIG_W])
        begin
            fracOut = sigRounded[`FP_SIG_W-1:1];                // 1.11..1 rolled over to 10.00..0
            expFinal = expNorm + ExpW'(1);
        end
        else
        begin
            fracOut = sigRounded[`FP_MAN_W-1:0];
            expFinal = expNorm;
        end

        if (sum.isZero)
            resultNext = '0;                                    // +0
        else if (expFinal >= ExpMax)
            resultNext = {sum.sign, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};     // Signed infinity
        else if (expFinal <= 0)
            resultNext = {sum.sign, {(`FP_EXP_W+`FP_MAN_W){1'b0}}};             // Flush to zero
        else
            resultNext = {sum.sign, expFinal[`FP_EXP_W-1:0], fracOut};
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            outValid <= 1'b0;
            result <= '0;
        end
        else
        begin
            outValid <= sumValid;
            result <= resultNext;
        end
    end

endmodule

`default_nettype wire

//--- design/FpAdder.sv
`timescale 1ns/1ps
`default_nettype none

module FpAdder
(
    input  logic clk,
    input  logic reset,
    input  logic inValid,
    input  fpAdderPkg::floatWord_t operandA,
    input  fpAdderPkg::floatWord_t operandB,
    output logic outValid,
    output fpAdderPkg::floatWord_t result
);

    logic alignValid;                                           // Stage 1 strobe
    fpAdderPkg::alignedPair_t aligned;                          // Aligned significands
    logic sumValid;                                             // Stage 2 strobe
    fpAdderPkg::sumResult_t sum;                                // Raw sum before normalization

    // Stage 1, exponent compare and alignment
    Alignment alignStage
    (
        .clk        (clk),
        .reset      (reset),
        .inValid    (inValid),
        .operandA   (fpAdderPkg::operand_t'(operandA)),         // Same layout as the IEEE word
        .operandB   (fpAdderPkg::operand_t'(operandB)),
        .alignValid (alignValid),
        .aligned    (aligned)
    );

    // Stage 2, effective add or subtract
    SignificandAdder addStage
    (
        .clk        (clk),
        .reset      (reset),
        .alignValid (alignValid),
        .aligned    (aligned),
        .sumValid   (sumValid),
        .sum        (sum)
    );

    // Stage 3, normalize, round, pack
    NormalizeRound roundStage
    (
        .clk        (clk),
        .reset      (reset),
        .sumValid   (sumValid),
        .sum        (sum),
        .outValid   (outValid),
        .result     (result)
    );

endmodule

`default_nettype wire

//--- dv/fpAddModel.svh
`ifndef FP_ADD_MODEL_SVH
`define FP_ADD_MODEL_SVH

// Reference adder for normal operands, nearest-even rounding, flush to zero on underflow
function automatic fpAdderPkg::floatWord_t fpAddModel(input fpAdderPkg::floatWord_t a,
                                                      input fpAdderPkg::floatWord_t b);
    fpAdderPkg::floatWord_t bigWord;                            // Operand with the larger exponent
    fpAdderPkg::floatWord_t smallWord;                          // Operand that gets aligned
    int expBig;
    int expDiff;
    int shift;
    logic [63:0] wideSmall;                                     // Small significand slid down from the top
    logic [26:0] magBig;                                        // Significand then three zero bits
    logic [26:0] magSmall;                                      // Significand, guard, round, sticky
    logic [27:0] total;                                         // Carry bit on top
    logic [25:0] upper;                                         // Significand, guard, round
    logic [23:0] sig;
    logic [24:0] sigUp;
    logic signOut;
    logic guard;
    logic round;
    logic sticky;

    bigWord = (a[30:23] >= b[30:23]) ? a : b;
    smallWord = (a[30:23] >= b[30:23]) ? b : a;
    expBig = int'(bigWord[30:23]);
    expDiff = expBig - int'(smallWord[30:23]);
    if (expDiff > 30)
        expDiff = 30;                                           // Past 26 every bit is sticky anyway

    wideSmall = {1'b1, smallWord[22:0], 40'b0} >> expDiff;
    magSmall = {wideSmall[63:38], |wideSmall[37:0]};
    magBig = {1'b1, bigWord[22:0], 3'b000};

    if (bigWord[31] == smallWord[31])
    begin
        total = {1'b0, magBig} + {1'b0, magSmall};
        signOut = bigWord[31];
    end
    else if (magBig >= magSmall)
    begin
        total = {1'b0, magBig} - {1'b0, magSmall};
        signOut = bigWord[31];
    end
    else
    begin
        total = {1'b0, magSmall} - {1'b0, magBig};              // Only with equal exponents
        signOut = smallWord[31];
    end

    if (total == '0)
        return '0;                                              // Exact cancellation

    if (total[27])
    begin
        sig = total[27:4];
        guard = total[3];
        round = total[2];
        sticky = total[1] | total[0];
        expBig = expBig + 1;
    end
    else
    begin
        upper = total[26:1];
        shift = 0;
        while (!upper[25] && shift < 26)
        begin
            upper = upper << 1;                                 // Zeros come in below round
            shift++;
        end
        sig = upper[25:2];
        guard = upper[1];
        round = upper[0];
        sticky = total[0];
        expBig = expBig - shift;
    end

    sigUp = {1'b0, sig} + 25'(guard & (round | sticky | sig[0]));
    if (sigUp[24])
    begin
        sigUp = sigUp >> 1;                                     // Rounded up to the next power of two
        expBig = expBig + 1;
    end

    if (expBig >= 255)
        return {signOut, 8'hff, 23'h0};
    if (expBig <= 0)
        return {signOut, 31'h0};
    return {signOut, expBig[7:0], sigUp[22:0]};
endfunction

`endif

//--- dv/FpAdderTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "fpAdder_config.svh"

module FpAdderTb;

    localparam int WaitLimit = 20;                              // Cycles a drain may take

    logic clk;
    logic reset;
    logic inValid;
    fpAdderPkg::floatWord_t operandA;
    fpAdderPkg::floatWord_t operandB;
    logic outValid;
    fpAdderPkg::floatWord_t result;

    fpAdderPkg::floatWord_t expectQ[$];                         // Expected results in issue order
    logic [31:0] rngState;
    int checkCount;
    int errorCount;
    int testChecks;                                             // Counts when the test began
    int testErrors;

    `include "fpAddModel.svh"

    FpAdder FpAdder_i
    (
        .clk      (clk),
        .reset    (reset),
        .inValid  (inValid),
        .operandA (operandA),
        .operandB (operandB),
        .outValid (outValid),
        .result   (result)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #50 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);                 // xorshift32
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic int randomRange(input int lo, input int hi);
        logic [31:0] r;
        r = nextRandom();
        return lo + int'(r % (hi - lo + 1));
    endfunction

    function automatic logic randomBit();
        logic [31:0] r;
        r = nextRandom();
        return r[31];
    endfunction

    function automatic logic [22:0] randomFrac();
        logic [31:0] r;
        r = nextRandom();
        return r[22:0];
    endfunction

    function automatic fpAdderPkg::floatWord_t makeWord(input logic sign, input int exponent,
                                                        input logic [22:0] frac);
        return {sign, exponent[7:0], frac};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic finishRun();
        $display("Totals: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    endtask

    task automatic reportFailure(input string why);
        errorCount++;
        $display("%s", why);
    endtask

    // Drives one pair for one cycle and leaves inValid up for the next call
    task automatic sendPair(input fpAdderPkg::floatWord_t a, input fpAdderPkg::floatWord_t b,
                            input fpAdderPkg::floatWord_t expected);
        @(posedge clk);
        #1;
        inValid = 1'b1;
        operandA = a;
        operandB = b;
        expectQ.push_back(expected);
    endtask

    task automatic sendModel(input fpAdderPkg::floatWord_t a, input fpAdderPkg::floatWord_t b);
        sendPair(a, b, fpAddModel(a, b));
    endtask

    task automatic endTest(input string name);
        int waited;
        @(posedge clk);
        #1;
        inValid = 1'b0;
        waited = 0;
        while (expectQ.size() != 0 && waited < WaitLimit)
        begin
            @(posedge clk);
            waited++;
        end
        if (expectQ.size() != 0)
        begin
            reportFailure($sformatf("%s: %0d results never came out", name, expectQ.size()));
            expectQ.delete();                                   // Next test starts with an empty pipe
        end
        $display("%s: %0d checks, %0d errors", name, checkCount - testChecks,
                 errorCount - testErrors);
        testChecks = checkCount;
        testErrors = errorCount;
    endtask

    // Scoreboard samples on the falling edge where results are stable
    always @(negedge clk)
    begin
        if (!reset && outValid)
        begin
            if (expectQ.size() == 0)
                reportFailure("outValid went high with no pair in flight");
            else
                checkValue("result", result, expectQ.pop_front());
        end
    end

    initial
    begin
        fpAdderPkg::floatWord_t a;
        fpAdderPkg::floatWord_t b;
        fpAdderPkg::floatWord_t expected;
        logic [22:0] frac;
        logic [22:0] fracB;
        logic sign;
        int expA;
        int expB;
        int delta;
        int latency;

        rngState = 32'h04cbad01;
        checkCount = 0;
        errorCount = 0;
        testChecks = 0;
        testErrors = 0;
        reset = 1'b1;
        inValid = 1'b0;
        operandA = '0;
        operandB = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        // Idle pipe followed by one pair timed from issue to outValid
        for (int i = 0; i < 10; i++)
        begin
            @(posedge clk);
            #1;
            checkValue("outValid", 32'(outValid), 32'h0);
        end
        sendModel(makeWord(1'b0, 127, randomFrac()), makeWord(1'b0, 126, randomFrac()));
        @(posedge clk);
        #1;
        inValid = 1'b0;
        latency = 1;
        while (!outValid && latency < WaitLimit)
        begin
            @(posedge clk);
            #1;
            latency++;
        end
        if (!outValid)
            reportFailure("single pair never raised outValid");
        else
            checkValue("latency", latency, `FP_PIPE_DEPTH);
        endTest("reset and latency");

        for (int i = 0; i < 300; i++)
        begin
            sign = randomBit();
            expA = randomRange(40, 254);
            delta = randomRange(0, 36);
            a = makeWord(sign, expA, randomFrac());
            b = makeWord(sign, expA - delta, randomFrac());
            if (delta >= 26)
            begin
                checkValue("fpAddModel", fpAddModel(b, a), a);  // Sticky-only loss keeps a
                sendPair(b, a, a);
            end
            else
                sendModel(a, b);
        end
        endTest("same-sign addition");

        for (int i = 0; i < 200; i++)
        begin
            sign = randomBit();
            expA = randomRange(2, 254);
            frac = randomFrac();
            a = makeWord(sign, expA, frac);
            b = makeWord(!sign, expA - randomRange(0, 1),
                         frac ^ (randomFrac() >> randomRange(0, 22)));  // Shared top bits
            sendModel(a, b);
        end
        for (int i = 0; i < 20; i++)
        begin
            a = makeWord(randomBit(), randomRange(1, 254), randomFrac());
            checkValue("fpAddModel", fpAddModel(a, a ^ 32'h80000000), 32'h0);
            sendPair(a, a ^ 32'h80000000, 32'h0);               // x - x is +0
        end
        endTest("opposite-sign cancellation");

        for (int i = 0; i < 200; i++)
        begin
            sign = randomBit();
            expA = randomRange(3, 250);
            delta = randomRange(1, 2);
            frac = randomFrac();
            if (delta == 1)
                frac[0] = 1'b1;                                 // Becomes guard, nothing below
            else
                frac[1:0] = 2'b10;
            a = makeWord(sign, expA, randomFrac());
            b = makeWord((i % 4 == 3) ? !sign : sign, expA - delta, frac);
            sendModel(b, a);
        end
        endTest("rounding ties");

        for (int i = 0; i < 50; i++)
        begin
            sign = randomBit();
            a = makeWord(sign, 254, randomFrac());
            expected = {sign, 8'hff, 23'h0};
            checkValue("fpAddModel", fpAddModel(a, a), expected);
            sendPair(a, a, expected);                           // Doubling the top exponent
            sendModel(a, makeWord(sign, randomRange(240, 254), randomFrac()));
        end
        for (int i = 0; i < 50; i++)
        begin
            sign = randomBit();
            frac = randomFrac();
            fracB = randomFrac();
            if (fracB == frac)
                fracB = frac ^ 23'h1;
            a = makeWord(sign, 1, frac);
            b = makeWord(!sign, 1, fracB);
            expected = {(frac > fracB) ? sign : !sign, 31'h0};  // Difference is below normal range
            checkValue("fpAddModel", fpAddModel(a, b), expected);
            sendPair(a, b, expected);
        end
        endTest("overflow and underflow");

        for (int i = 0; i < 2000; i++)
        begin
            expA = randomRange(1, 254);
            delta = (i % 2 == 0) ? randomRange(-2, 2) : randomRange(-60, 60);
            expB = expA + delta;
            if (expB < 1)
                expB = 1;
            if (expB > 254)
                expB = 254;
            a = makeWord(randomBit(), expA, randomFrac());
            b = makeWord(randomBit(), expB, randomFrac());
            sendModel(a, b);
        end
        endTest("back-to-back random");

        finishRun();
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+design
+incdir+dv
design/fpAdderPkg.sv
design/Alignment.sv
design/SignificandAdder.sv
design/NormalizeRound.sv
design/FpAdder.sv
dv/FpAdderTb.sv

//--- Makefile
# Verilator build and run for the floating-point adder testbench

SIM        := verilator
TOP        := FpAdderTb
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "Simulation did not finish"; exit 1; fi

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
